/* list.f */
rtl/wb_lsu_pkg.sv
rtl/wb_encode_decode.sv
rtl/wb_lsu_master.sv
rtl/wb_sram.sv
rtl/wb_lsu_top.sv
test/wb_lsu_asserts.sv
test/tb_wb_lsu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_wb_lsu
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Result: PASSED$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_wb_lsu.sv */
module tb_wb_lsu
    import wb_lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // about 650 ops of at most 5 cycles each with slack for reset and gaps
    localparam int MAX_OPS     = 700;
    localparam int OP_CYCLES   = 5;
    localparam int CYCLE_LIMIT = MAX_OPS * OP_CYCLES + 1500;

    // one outstanding operation as the compare process expects it
    typedef struct packed {
        logic              is_load;
        logic              err;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   data;
    } exp_t;

    logic            clk;
    logic            rst_n;
    logic            req_valid;
    lsu_req_t        req;
    logic            busy;
    logic            done;
    logic            err;
    logic [XLEN-1:0] rdata;

    // mirror of the memory whose word index wraps the same way
    logic [XLEN-1:0] mirror [MEM_WORDS];
    exp_t            exp_q [$];
    exp_t            cur;
    int              err_cnt;
    int              pass_cnt;
    int              test_errs;
    int              cycle_cnt;
    integer          seed;

    wb_lsu_top UUT (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .busy_o      (busy),
        .done_o      (done),
        .err_o       (err),
        .rdata_o     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic is_misaligned(lsu_size_e size, logic [ADDR_W-1:0] addr);
        return ((size == SIZE_HALF) && addr[0]) ||
               ((size == SIZE_WORD) && (addr[1:0] != 2'b00));
    endfunction

    // expected load result from the mirror word
    function automatic logic [XLEN-1:0] exp_load(logic [XLEN-1:0] word,
            logic [ADDR_W-1:0] addr, lsu_size_e size, logic uns);
        logic [XLEN-1:0] sh;
        case (size)
            SIZE_BYTE: begin
                sh = word >> (8 * addr[1:0]);
                return uns ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            end
            SIZE_HALF: begin
                sh = word >> (16 * addr[1]);
                return uns ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            end
            default: return word;
        endcase
    endfunction

    // mirror word after a store of the given size lands at addr
    function automatic logic [XLEN-1:0] merge_store(logic [XLEN-1:0] word,
            logic [ADDR_W-1:0] addr, lsu_size_e size, logic [XLEN-1:0] data);
        logic [XLEN-1:0] m;
        m = word;
        case (size)
            SIZE_BYTE: m[8 * addr[1:0] +: 8] = data[7:0];
            SIZE_HALF: m[16 * addr[1] +: 16] = data[15:0];
            default:   m = data;
        endcase
        return m;
    endfunction

    function automatic lsu_size_e pick_size(logic [1:0] v);
        case (v)
            2'd0:    return SIZE_BYTE;
            2'd1:    return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    task automatic check_val(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
            input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the edge that ends done
    task automatic issue_op(input logic we, input lsu_size_e size, input logic uns,
            input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] wdata);
        exp_t e;
        e.is_load = !we;
        e.err     = is_misaligned(size, addr);
        e.addr    = addr;
        e.data    = '0;
        if (!e.err && we) begin
            mirror[addr[OFS_W +: MEM_AW]] = merge_store(mirror[addr[OFS_W +: MEM_AW]],
                                                        addr, size, wdata);
        end else if (!e.err) begin
            e.data = exp_load(mirror[addr[OFS_W +: MEM_AW]], addr, size, uns);
        end
        // master must be idle before a new strobe
        check_val(XLEN'(busy), '0, $sformatf("busy before request at %h", addr));
        exp_q.push_back(e);
        req_valid = 1'b1;
        req.we    = we;
        req.size  = size;
        req.uns   = uns;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        // busy rises at the capture edge
        check_val(XLEN'(busy), XLEN'(1'b1), $sformatf("busy after capture at %h", addr));
        while (!done) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        $display("test %-16s %s, %0d errors", name,
                 (err_cnt == test_errs) ? "ok" : "mismatch", err_cnt - test_errs);
        test_errs = err_cnt;
    endtask

    // compare on the falling edge where done is stable for a full cycle
    always @(negedge clk) begin
        if (rst_n && done) begin
            if (exp_q.size() == 0) begin
                $display("done pulse at %0t ns with no request outstanding", $time);
                err_cnt++;
            end else begin
                cur = exp_q.pop_front();
                check_val(XLEN'(err), XLEN'(cur.err), $sformatf("err flag at %h", cur.addr));
                check_val(XLEN'(busy), XLEN'(1'b1),
                          $sformatf("busy in done cycle at %h", cur.addr));
                if (cur.is_load && !cur.err) begin
                    check_val(rdata, cur.data, $sformatf("load data at %h", cur.addr));
                end
            end
        end
    end

    // cycle counter that stops a hung run
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r_addr;
        logic [31:0] r_data;
        logic [31:0] r_ctl;
        seed      = 32'heff7;
        err_cnt   = 0;
        pass_cnt  = 0;
        test_errs = 0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mirror[w] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // 0x3fc, 0x7fc and 0xbfc all alias onto wrapped index 255
        for (int i = 0; i < 6; i++) begin
            issue_op(1'b1, SIZE_WORD, 1'b0, (i < 3) ? 32'h4 * i : 32'h400 * (i - 2) - 32'h4,
                     $random(seed));
        end
        for (int i = 0; i < 6; i++) begin
            issue_op(1'b0, SIZE_WORD, 1'b0, (i < 3) ? 32'h4 * i : 32'h400 * (i - 2) - 32'h4,
                     '0);
        end
        finish_test("word_rw");

        // junk above the low byte must not reach memory
        issue_op(1'b1, SIZE_BYTE, 1'b0, 32'h80, 32'hA5C3E711);
        issue_op(1'b1, SIZE_BYTE, 1'b0, 32'h81, 32'hA5C3E722);
        issue_op(1'b1, SIZE_BYTE, 1'b0, 32'h82, 32'hA5C3E733);
        issue_op(1'b1, SIZE_BYTE, 1'b0, 32'h83, 32'hA5C3E744);
        issue_op(1'b0, SIZE_WORD, 1'b0, 32'h80, '0);
        finish_test("byte_merge");

        issue_op(1'b1, SIZE_WORD, 1'b0, 32'h100, 32'h80017FFE);
        issue_op(1'b1, SIZE_WORD, 1'b0, 32'h104, 32'h7F0080FF);
        for (int i = 0; i < 8; i++) begin
            issue_op(1'b0, SIZE_HALF, i[0], 32'h100 + 32'h4 * i[2] + 32'h2 * i[1], '0);
        end
        finish_test("half_load");

        issue_op(1'b1, SIZE_WORD, 1'b0, 32'h200, 32'h807FFF01);
        for (int i = 0; i < 8; i++) begin
            issue_op(1'b0, SIZE_BYTE, i[0], 32'h200 + 32'(i[2:1]), '0);
        end
        finish_test("byte_load");

        // refused requests leave the word as it was
        issue_op(1'b1, SIZE_WORD, 1'b0, 32'h300, 32'h5A5AA5A5);
        issue_op(1'b1, SIZE_HALF, 1'b0, 32'h301, 32'hFFFFFFFF);
        issue_op(1'b1, SIZE_WORD, 1'b0, 32'h302, 32'hFFFFFFFF);
        issue_op(1'b1, SIZE_WORD, 1'b0, 32'h303, 32'hFFFFFFFF);
        issue_op(1'b0, SIZE_HALF, 1'b1, 32'h303, '0);
        issue_op(1'b0, SIZE_WORD, 1'b0, 32'h301, '0);
        issue_op(1'b0, SIZE_WORD, 1'b0, 32'h300, '0);
        finish_test("misaligned");

        // 16 words with random upper bits so reads hit earlier writes
        for (int i = 0; i < 600; i++) begin
            r_addr = $random(seed);
            r_data = $random(seed);
            r_ctl  = $random(seed);
            issue_op(r_ctl[2], pick_size(r_ctl[1:0]), r_ctl[3], r_addr & 32'hFFFFF03F, r_data);
        end
        finish_test("random_mix");

        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d requests never answered with done", exp_q.size());
            err_cnt++;
        end
        $display("checks passed %0d, errors %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* test/wb_lsu_asserts.sv */
module wb_lsu_asserts
    import wb_lsu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  lsu_req_t req_i,
    input  logic     busy_i,
    input  logic     done_i,
    input  wb_m2s_t  m2s_i,
    input  wb_s2m_t  s2m_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // request taken this edge that the master has to refuse
    logic mis_req;

    assign mis_req = req_valid_i && !busy_i &&
                     (((req_i.size == SIZE_HALF) && req_i.addr[0]) ||
                      ((req_i.size == SIZE_WORD) && (req_i.addr[1:0] != 2'b00)));

    // an open cycle keeps cyc and stb up until the slave answers
    stb_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (m2s_i.stb && !s2m_i.ack) |=> (m2s_i.stb && m2s_i.cyc))
        else $error("cyc or stb dropped before ack");

    // wait states hold every bus field
    bus_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (m2s_i.stb && !s2m_i.ack) |=> ($stable(m2s_i.adr) && $stable(m2s_i.sel) &&
                                       $stable(m2s_i.we) && $stable(m2s_i.dat)))
        else $error("bus fields changed while waiting for ack");

    done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else $error("done lasted more than one cycle");

    // only single lanes, aligned halves or the full word reach the bus
    sel_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m2s_i.cyc |-> (m2s_i.sel inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                         4'b0011, 4'b1100, 4'b1111}))
        else $error("illegal byte select during a bus cycle");

    mis_no_bus: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mis_req |=> !m2s_i.cyc)
        else $error("bus cycle started for a misaligned request");

endmodule

bind wb_lsu_master wb_lsu_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_i      (busy_o),
    .done_i      (done_o),
    .m2s_i       (wb_o),
    .s2m_i       (wb_i)
);

/* rtl/wb_lsu_top.sv */
module wb_lsu_top
    import wb_lsu_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            req_valid_i,
    input  lsu_req_t        req_i,
    output logic            busy_o,
    output logic            done_o,
    output logic            err_o,
    output logic [XLEN-1:0] rdata_o
);

    wb_m2s_t          m2s;
    wb_s2m_t          s2m;
    logic [SEL_W-1:0] lane_sel;
    lsu_size_e        lane_size;
    logic             lane_uns;
    logic [XLEN-1:0]  lane_wdata;
    logic [XLEN-1:0]  lane_rdata;

    // request capture, alignment check and the bus FSM
    wb_lsu_master u_master (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .err_o        (err_o),
        .rdata_o      (rdata_o),
        .wb_o         (m2s),
        .wb_i         (s2m),
        .lane_sel_o   (lane_sel),
        .lane_size_o  (lane_size),
        .lane_uns_o   (lane_uns),
        .lane_wdata_i (lane_wdata),
        .lane_rdata_i (lane_rdata)
    );

    // store data comes straight from the core port
    // the master samples the laned word when it takes the request
    wb_encode_decode u_lanes (
        .sel_i        (lane_sel),
        .size_i       (lane_size),
        .uns_i        (lane_uns),
        .bus_rdata_i  (s2m.dat),
        .store_data_i (req_i.wdata),
        .load_data_o  (lane_rdata),
        .bus_wdata_o  (lane_wdata)
    );

    // single slave, no address decode
    wb_sram u_sram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wb_i    (m2s),
        .wb_o    (s2m)
    );

endmodule

/* rtl/wb_sram.sv */
module wb_sram
    import wb_lsu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  wb_m2s_t wb_i,
    output wb_s2m_t wb_o
);

    logic [XLEN-1:0]    mem_q [MEM_WORDS];
    logic [MEM_AW-1:0]  idx;
    logic [WAIT_CW-1:0] cnt_q;
    logic               ack_q;
    logic [XLEN-1:0]    rdat_q;
    // a cycle is open and not yet answered
    logic               pending;
    // the edge on which ack is raised and the access happens
    logic               fire;

    // word index from the bits above the byte offset, wraps
    assign idx = wb_i.adr[OFS_W +: MEM_AW];

    assign pending = wb_i.cyc && wb_i.stb && !ack_q;
    assign fire    = pending && (cnt_q == WAIT_CW'(SRAM_WAIT));

    // wait counter and ack
    // ack rises SRAM_WAIT+1 cycles after stb and lasts one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= fire;
            if (!pending || fire) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // storage, cleared on reset so contents start at zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (fire && wb_i.we) begin
            // only the enabled byte lanes are written
            for (int b = 0; b < SEL_W; b++) begin
                if (wb_i.sel[b]) begin
                    mem_q[idx][b * 8 +: 8] <= wb_i.dat[b * 8 +: 8];
                end
            end
        end
    end

    // read word, sampled on the ack edge so it lines up with ack
    always_ff @(posedge clk_i) begin
        if (fire && !wb_i.we) begin
            rdat_q <= mem_q[idx];
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdat_q;

endmodule

/* rtl/wb_lsu_master.sv */
module wb_lsu_master
    import wb_lsu_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            req_valid_i,
    input  lsu_req_t        req_i,
    output logic            busy_o,
    output logic            done_o,
    output logic            err_o,
    output logic [XLEN-1:0] rdata_o,
    output wb_m2s_t         wb_o,
    input  wb_s2m_t         wb_i,
    output logic [SEL_W-1:0] lane_sel_o,
    output lsu_size_e       lane_size_o,
    output logic            lane_uns_o,
    input  logic [XLEN-1:0] lane_wdata_i,
    input  logic [XLEN-1:0] lane_rdata_i
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_BUS  = 2'b01,
        ST_DONE = 2'b10
    } state_e;

    state_e           state_q;
    lsu_req_t         req_q;
    // request seen by the lane logic, live port while idle
    lsu_req_t         cur_req;
    logic [SEL_W-1:0] sel_c;
    logic             misaligned_c;
    logic             accept;
    logic             err_q;
    logic [XLEN-1:0]  wdat_q;
    logic [XLEN-1:0]  rdata_q;

    // byte enables for a given size and byte offset
    function automatic logic [SEL_W-1:0] sel_of(lsu_size_e size, logic [OFS_W-1:0] ofs);
        case (size)
            SIZE_BYTE: sel_of = SEL_W'(1) << ofs;
            SIZE_HALF: sel_of = SEL_W'(3) << ofs;
            default:   sel_of = '1;
        endcase
    endfunction

    // half needs an even address, word needs both low bits clear
    function automatic logic misaligned_of(lsu_size_e size, logic [OFS_W-1:0] ofs);
        case (size)
            SIZE_BYTE: misaligned_of = 1'b0;
            SIZE_HALF: misaligned_of = ofs[0];
            default:   misaligned_of = |ofs;
        endcase
    endfunction

    // while idle the lane logic works on the incoming request
    // so the laned store word is ready at the capture edge
    assign cur_req      = (state_q == ST_IDLE) ? req_i : req_q;
    assign sel_c        = sel_of(cur_req.size, cur_req.addr[OFS_W-1:0]);
    assign misaligned_c = misaligned_of(cur_req.size, cur_req.addr[OFS_W-1:0]);
    assign accept       = (state_q == ST_IDLE) && req_valid_i;

    // control FSM
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        err_q <= misaligned_c;
                        // a misaligned request skips the bus entirely
                        state_q <= misaligned_c ? ST_DONE : ST_BUS;
                    end
                end
                ST_BUS: begin
                    // slave wait states keep us here with the bus held
                    if (wb_i.ack) begin
                        state_q <= ST_DONE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // request payload, taken once at the capture edge
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q  <= req_i;
            wdat_q <= lane_wdata_i;
        end
    end

    // extended load data, updated only by a load ack
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_BUS) && wb_i.ack && !req_q.we) begin
            rdata_q <= lane_rdata_i;
        end
    end

    // bus side
    // all fields come from registers, stable for the whole cycle
    assign wb_o.cyc = (state_q == ST_BUS);
    assign wb_o.stb = (state_q == ST_BUS);
    assign wb_o.we  = req_q.we;
    // word aligned address, lanes pick the bytes
    assign wb_o.adr = {req_q.addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
    assign wb_o.sel = sel_c;
    assign wb_o.dat = wdat_q;

    // lane steering controls
    assign lane_sel_o  = sel_c;
    assign lane_size_o = cur_req.size;
    assign lane_uns_o  = cur_req.uns;

    // core side
    assign busy_o  = (state_q != ST_IDLE);
    assign done_o  = (state_q == ST_DONE);
    assign err_o   = done_o & err_q;
    assign rdata_o = rdata_q;

endmodule

/* rtl/wb_encode_decode.sv */
module wb_encode_decode
    import wb_lsu_pkg::*;
(
    input  logic [SEL_W-1:0] sel_i,
    input  lsu_size_e        size_i,
    input  logic             uns_i,
    input  logic [XLEN-1:0]  bus_rdata_i,
    input  logic [XLEN-1:0]  store_data_i,
    output logic [XLEN-1:0]  load_data_o,
    output logic [XLEN-1:0]  bus_wdata_o
);

    // lowest selected lane gives the byte offset of the access
    logic [OFS_W-1:0] ofs;
    // halfword slot inside the word, upper offset bit
    logic             half_idx;
    logic [7:0]       lane_byte;
    logic [15:0]      lane_half;
    // fill bit for the upper part of an extended load
    logic             fill_bit;

    // priority encode from the top so the lowest set bit wins
    always_comb begin
        ofs = '0;
        for (int i = SEL_W - 1; i >= 0; i--) begin
            if (sel_i[i]) begin
                ofs = OFS_W'(i);
            end
        end
    end

    assign half_idx = ofs[OFS_W-1];

    // store side
    // byte and halfword data is copied onto every lane
    // whichever lane sel enables then carries the right value
    always_comb begin
        case (size_i)
            SIZE_BYTE: bus_wdata_o = {SEL_W{store_data_i[7:0]}};
            SIZE_HALF: bus_wdata_o = {(SEL_W / 2){store_data_i[15:0]}};
            default:   bus_wdata_o = store_data_i;
        endcase
    end

    // load side
    // pick the addressed byte or halfword out of the bus word
    assign lane_byte = bus_rdata_i[ofs * 8 +: 8];
    assign lane_half = bus_rdata_i[half_idx * 16 +: 16];

    // sign of the picked value, forced low for unsigned loads
    always_comb begin
        case (size_i)
            SIZE_BYTE: fill_bit = ~uns_i & lane_byte[7];
            SIZE_HALF: fill_bit = ~uns_i & lane_half[15];
            default:   fill_bit = 1'b0;
        endcase
    end

    always_comb begin
        case (size_i)
            SIZE_BYTE: load_data_o = {{(XLEN - 8){fill_bit}}, lane_byte};
            SIZE_HALF: load_data_o = {{(XLEN - 16){fill_bit}}, lane_half};
            // full word goes through untouched
            default:   load_data_o = bus_rdata_i;
        endcase
    end

endmodule

/* rtl/wb_lsu_pkg.sv */
package wb_lsu_pkg;

    // data path and address widths
    localparam int XLEN   = 32;
    localparam int ADDR_W = 32;

    // one select bit per byte lane
    localparam int SEL_W = XLEN / 8;

    // bits of byte offset inside one bus word
    localparam int OFS_W = $clog2(SEL_W);

    // memory depth in words, index wraps at MEM_WORDS
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    // wait states inserted by the memory before ack
    localparam int SRAM_WAIT = 1;

    // wait counter width, wide enough for SRAM_WAIT itself
    localparam int WAIT_CW = $clog2(SRAM_WAIT + 2);

    // access size as issued by the core
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } lsu_size_e;

    // core side load/store request
    typedef struct packed {
        logic              we;
        lsu_size_e         size;
        // zero extend on load when set
        logic              uns;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
    } lsu_req_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [SEL_W-1:0]  sel;
        logic [XLEN-1:0]   dat;
    } wb_m2s_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_s2m_t;

endpackage
